// ==== source/rmt_consts.svh ====
`ifndef RMT_CONSTS_SVH
`define RMT_CONSTS_SVH

// stream beat
`define RMT_DATA_W 64
`define RMT_KEEP_W 8

// header vector
`define RMT_CONT_W 16
`define RMT_NUM_CONT 3
`define RMT_PHV_W (`RMT_NUM_CONT * `RMT_CONT_W)
`define RMT_NUM_STAGES `RMT_NUM_CONT

// vlan id at the top of the first beat, containers at the bottom
`define RMT_VLAN_W 12
`define RMT_VLAN_MSB 63
`define RMT_VLAN_LSB (`RMT_VLAN_MSB - `RMT_VLAN_W + 1)

// fifo sizing
`define RMT_PKT_DEPTH_BITS 4
`define RMT_PHV_DEPTH_BITS 3
// parser register plus stage registers plus the beat being accepted
`define RMT_PHV_MARGIN (`RMT_NUM_STAGES + 2)

`endif

// ==== source/rmt_pkg.sv ====
`include "rmt_consts.svh"

package rmt_pkg;

	typedef logic [`RMT_DATA_W-1:0] data_t;
	typedef logic [`RMT_KEEP_W-1:0] keep_t;
	typedef logic [`RMT_VLAN_W-1:0] vlan_id_t;
	typedef logic [`RMT_CONT_W-1:0] container_t;

	// one stream beat
	typedef struct packed {
		data_t data;
		keep_t keep;
		logic  last;
	} beat_t;

	// container 0 is the most significant, same order as in the first beat
	typedef struct packed {
		container_t [0:`RMT_NUM_CONT-1] cont;
	} phv_t;

endpackage

// ==== source/header_parser.sv ====
`timescale 1ns/10ps
`include "rmt_consts.svh"

module header_parser import rmt_pkg::*; (
	input  logic        clk,
	input  logic        aresetn,
	input  beat_t       s_beat,
	input  logic        s_valid,
	output logic        s_ready,
	input  logic [31:0] vlan_drop_flags,
	input  logic        pkt_nearly_full,
	input  logic        phv_nearly_full,
	output logic        pkt_wr,
	output beat_t       pkt_beat,
	output logic        phv_valid,
	output phv_t        phv
);

	typedef enum logic {
		st_idle,
		st_in_pkt
	} state_t;

	state_t   state;
	logic     running;
	logic     drop_q;
	vlan_id_t vlan;
	logic     first;
	logic     flagged;
	logic     accept;
	logic     keep_beat;

	assign vlan = s_beat.data[`RMT_VLAN_MSB:`RMT_VLAN_LSB];
	assign first = (state == st_idle);
	assign flagged = vlan_drop_flags[vlan[4:0]];

	// held low until the first cycle out of reset
	assign s_ready = running & ~pkt_nearly_full & ~phv_nearly_full;
	assign accept = s_valid & s_ready;

	// body beats follow the decision of their first beat
	assign keep_beat = first ? ~flagged : ~drop_q;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			running <= 1'b0;
			state <= st_idle;
			drop_q <= 1'b0;
			pkt_wr <= 1'b0;
			phv_valid <= 1'b0;
		end else begin
			running <= 1'b1;
			pkt_wr <= accept & keep_beat;
			phv_valid <= accept & keep_beat & first;
			if (accept) begin
				if (first)
					drop_q <= flagged;
				state <= s_beat.last ? st_idle : st_in_pkt;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pkt_beat <= s_beat;
			// containers sit in the low bits of the first beat
			phv <= s_beat.data[`RMT_PHV_W-1:0];
		end
	end

endmodule

// ==== source/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
	parameter int width = 8,
	parameter int depth_bits = 4,
	parameter int margin = 2
) (
	input  logic             clk,
	input  logic             aresetn,
	input  logic             wr_en,
	input  logic [width-1:0] din,
	input  logic             rd_en,
	output logic [width-1:0] dout,
	output logic             empty,
	output logic             nearly_full
);

	localparam int depth = 2 ** depth_bits;
	localparam int nf_level = depth - margin;

	logic [width-1:0]      mem [depth];
	logic [depth_bits-1:0] wr_ptr;
	logic [depth_bits-1:0] rd_ptr;
	logic [depth_bits:0]   count;
	logic                  rd_ok;

	// head entry visible without a read
	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	// fewer than margin free entries
	assign nearly_full = (int'(count) > nf_level);
	assign rd_ok = rd_en & ~empty;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			if (wr_en && !rd_ok)
				count <= count + 1'b1;
			else if (!wr_en && rd_ok)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== source/match_action_stage.sv ====
`timescale 1ns/10ps
`include "rmt_consts.svh"

module match_action_stage import rmt_pkg::*; #(
	parameter int stage_id = 0
) (
	input  logic clk,
	input  logic aresetn,
	input  logic in_valid,
	input  phv_t in_phv,
	output logic out_valid,
	output phv_t out_phv
);

	// neighbour container added into this stage's own container
	localparam int src_id = (stage_id + 1) % `RMT_NUM_CONT;

	phv_t phv_next;

	// sum wraps at 16 bits
	always_comb begin
		phv_next = in_phv;
		phv_next.cont[stage_id] = in_phv.cont[stage_id] + in_phv.cont[src_id];
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			out_phv <= phv_next;
	end

endmodule

// ==== source/deparser.sv ====
`timescale 1ns/10ps
`include "rmt_consts.svh"

module deparser import rmt_pkg::*; (
	input  logic  clk,
	input  logic  aresetn,
	input  beat_t pkt_head,
	input  logic  pkt_empty,
	input  phv_t  phv_head,
	input  logic  phv_empty,
	input  logic  m_ready,
	output logic  pkt_rd,
	output logic  phv_rd,
	output beat_t m_beat,
	output logic  m_valid
);

	typedef enum logic {
		st_hdr,
		st_body
	} state_t;

	state_t state;
	beat_t  hdr_beat;
	logic   in_hdr;
	logic   fire;

	// vlan and reserved bits stay, containers come from the phv
	always_comb begin
		hdr_beat = pkt_head;
		hdr_beat.data[`RMT_PHV_W-1:0] = phv_head;
	end

	assign in_hdr = (state == st_hdr);

	// first beat needs both heads, body beats only the packet fifo
	assign m_valid = in_hdr ? (~pkt_empty & ~phv_empty) : ~pkt_empty;
	assign m_beat = in_hdr ? hdr_beat : pkt_head;

	assign fire = m_valid & m_ready;
	assign pkt_rd = fire;
	assign phv_rd = fire & in_hdr;

	always_ff @(posedge clk) begin
		if (!aresetn)
			state <= st_hdr;
		else if (fire)
			state <= pkt_head.last ? st_hdr : st_body;
	end

endmodule

// ==== source/rmt_pipeline.sv ====
`timescale 1ns/10ps
`include "rmt_consts.svh"

module rmt_pipeline import rmt_pkg::*; (
	input  logic        clk,
	input  logic        aresetn,
	input  logic [31:0] vlan_drop_flags,
	input  beat_t       s_beat,
	input  logic        s_valid,
	output logic        s_ready,
	output beat_t       m_beat,
	output logic        m_valid,
	input  logic        m_ready
);

	logic  pkt_wr;
	beat_t pkt_beat;
	beat_t pkt_head;
	logic  pkt_empty;
	logic  pkt_rd;
	logic  pkt_nearly_full;

	phv_t phv_head;
	logic phv_empty;
	logic phv_rd;
	logic phv_nearly_full;

	// entry 0 from the parser, last entry into the phv fifo
	logic [`RMT_NUM_STAGES:0] stage_valid;
	phv_t                     stage_phv [`RMT_NUM_STAGES+1];

	header_parser header_parser_i (
		.clk             (clk),
		.aresetn         (aresetn),
		.s_beat          (s_beat),
		.s_valid         (s_valid),
		.s_ready         (s_ready),
		.vlan_drop_flags (vlan_drop_flags),
		.pkt_nearly_full (pkt_nearly_full),
		.phv_nearly_full (phv_nearly_full),
		.pkt_wr          (pkt_wr),
		.pkt_beat        (pkt_beat),
		.phv_valid       (stage_valid[0]),
		.phv             (stage_phv[0])
	);

	for (genvar g = 0; g < `RMT_NUM_STAGES; g++) begin : g_stage
		match_action_stage #(
			.stage_id (g)
		) stage_i (
			.clk       (clk),
			.aresetn   (aresetn),
			.in_valid  (stage_valid[g]),
			.in_phv    (stage_phv[g]),
			.out_valid (stage_valid[g+1]),
			.out_phv   (stage_phv[g+1])
		);
	end

	sync_fifo #(
		.width      ($bits(beat_t)),
		.depth_bits (`RMT_PKT_DEPTH_BITS),
		.margin     (2)
	) pkt_fifo_i (
		.clk         (clk),
		.aresetn     (aresetn),
		.wr_en       (pkt_wr),
		.din         (pkt_beat),
		.rd_en       (pkt_rd),
		.dout        (pkt_head),
		.empty       (pkt_empty),
		.nearly_full (pkt_nearly_full)
	);

	sync_fifo #(
		.width      ($bits(phv_t)),
		.depth_bits (`RMT_PHV_DEPTH_BITS),
		.margin     (`RMT_PHV_MARGIN)
	) phv_fifo_i (
		.clk         (clk),
		.aresetn     (aresetn),
		.wr_en       (stage_valid[`RMT_NUM_STAGES]),
		.din         (stage_phv[`RMT_NUM_STAGES]),
		.rd_en       (phv_rd),
		.dout        (phv_head),
		.empty       (phv_empty),
		.nearly_full (phv_nearly_full)
	);

	deparser deparser_i (
		.clk       (clk),
		.aresetn   (aresetn),
		.pkt_head  (pkt_head),
		.pkt_empty (pkt_empty),
		.phv_head  (phv_head),
		.phv_empty (phv_empty),
		.m_ready   (m_ready),
		.pkt_rd    (pkt_rd),
		.phv_rd    (phv_rd),
		.m_beat    (m_beat),
		.m_valid   (m_valid)
	);

endmodule

// ==== bench/rmt_pipeline_tb.sv ====
`timescale 1ns/10ps
`include "rmt_consts.svh"

module rmt_pipeline_tb import rmt_pkg::*; ();

	// about 70 packets of up to 8 beats, 2 cycles per beat, fourfold for drains and stalls
	localparam int max_packets = 70;
	localparam int max_beats = 8;
	localparam int timeout_cycles = max_packets * max_beats * 2 * 4 + 520;

	logic        clk;
	logic        aresetn;
	logic [31:0] vlan_drop_flags;
	beat_t       s_beat;
	logic        s_valid;
	logic        s_ready;
	beat_t       m_beat;
	logic        m_valid;
	logic        m_ready = 1'b0;

	integer seed;
	int     cycles = 0;
	int     rx_checks = 0;
	int     rx_errors = 0;
	int     tb_errors;
	int     errors_before;
	int     total_errors;
	logic   stall_random;
	logic   hold_low;
	beat_t  expected_q [$];

	initial clk = 1'b0;
	always #10 clk = ~clk;

	rmt_pipeline rmt_pipeline_i (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.s_beat          (s_beat),
		.s_valid         (s_valid),
		.s_ready         (s_ready),
		.m_beat          (m_beat),
		.m_valid         (m_valid),
		.m_ready         (m_ready)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: run stopped after %0d cycles, %0d beats still expected",
				cycles, expected_q.size());
			$display("Simulation FAILED");
			$finish;
		end
	end

	// sink ready, random or held low on request
	always @(posedge clk) begin : drive_ready
		logic ready_next;
		if (hold_low)
			ready_next = 1'b0;
		else if (stall_random)
			ready_next = (($random(seed) & 3) != 0);
		else
			ready_next = 1'b1;
		#1;
		m_ready = ready_next;
	end

	// handshake decided at the next rising edge, values stable at the falling one
	always @(negedge clk) begin : receive_beats
		beat_t exp_beat;
		if (aresetn && m_valid && m_ready) begin
			if (expected_q.size() == 0) begin
				$display("unexpected output beat %h at %0t with no packet pending",
					m_beat, $time);
				rx_errors++;
			end else begin
				exp_beat = expected_q.pop_front();
				rx_checks++;
				assert (m_beat == exp_beat) else begin
					$display("FAILED at %0t: beat %h, expected %h", $time, m_beat, exp_beat);
					rx_errors++;
				end
			end
		end
	end

	task automatic drive_beat(input beat_t beat);
		logic taken;
		s_beat = beat;
		s_valid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			taken = s_ready;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_packet(input vlan_id_t vlan, input container_t c0, c1, c2,
			input int len);
		container_t cont [`RMT_NUM_CONT];
		beat_t      beat;
		beat_t      exp_beat;
		logic [3:0] rsvd;
		logic       kept;
		rsvd = 4'($random(seed));
		kept = !vlan_drop_flags[vlan[4:0]];
		cont = '{c0, c1, c2};
		// stage s adds its right neighbour into container s, stages in order
		for (int s = 0; s < `RMT_NUM_STAGES; s++)
			cont[s] = cont[s] + cont[(s + 1) % `RMT_NUM_CONT];
		for (int b = 0; b < len; b++) begin
			if (b == 0)
				beat.data = {vlan, rsvd, c0, c1, c2};
			else
				beat.data = {$random(seed), $random(seed)};
			beat.keep = (b == len - 1) ? (keep_t'($random(seed)) | 8'h01) : 8'hff;
			beat.last = (b == len - 1);
			if (kept) begin
				exp_beat = beat;
				if (b == 0)
					exp_beat.data[`RMT_PHV_W-1:0] = {cont[0], cont[1], cont[2]};
				expected_q.push_back(exp_beat);
			end
			drive_beat(beat);
		end
		s_valid = 1'b0;
	endtask

	task automatic wait_drained(input int limit);
		int waited;
		waited = 0;
		while (expected_q.size() != 0 && waited < limit) begin
			@(posedge clk);
			waited++;
		end
		// room for a stray extra beat to show up
		repeat (3) @(posedge clk);
		#1;
		if (expected_q.size() != 0) begin
			$display("%0d expected beats never came out of the pipeline", expected_q.size());
			tb_errors++;
			expected_q.delete();
		end
	endtask

	task automatic report_test(input string name);
		int now;
		now = tb_errors + rx_errors;
		$display("test %s: %s", name, (now == errors_before) ? "ok" : "errors");
		errors_before = now;
	endtask

	task automatic single_beat_packet();
		logic seen;
		assert (m_valid == 1'b0) else begin
			$display("FAILED at %0t: m_valid high right after reset", $time);
			tb_errors++;
		end
		seen = 1'b0;
		for (int i = 0; i < 10 && !seen; i++) begin
			@(negedge clk);
			seen = s_ready;
		end
		@(posedge clk);
		#1;
		assert (seen) else begin
			$display("FAILED at %0t: s_ready did not rise after reset", $time);
			tb_errors++;
		end
		send_packet(12'h123, 16'h0001, 16'h0002, 16'h0003, 1);
		wait_drained(100);
		report_test("single beat packet");
	endtask

	task automatic multi_beat_packets();
		send_packet(12'h210, 16'h1111, 16'h2222, 16'h3333, 2);
		send_packet(12'h211, 16'hfff0, 16'h0020, 16'h8000, 5);
		send_packet(12'h212, 16'h0a0a, 16'h5050, 16'hffff, 8);
		wait_drained(200);
		report_test("multi beat packets");
	endtask

	task automatic vlan_drop();
		vlan_drop_flags = 32'h0000_8024;
		// low bits 2, 5 and 15 are flagged
		send_packet(12'h002, 16'h0101, 16'h0202, 16'h0303, 1);
		send_packet(12'h003, 16'h0404, 16'h0505, 16'h0606, 2);
		send_packet(12'h025, 16'h0707, 16'h0808, 16'h0909, 3);
		send_packet(12'h0a1, 16'h1010, 16'h2020, 16'h3030, 1);
		send_packet(12'h00f, 16'h4040, 16'h5050, 16'h6060, 4);
		send_packet(12'h010, 16'h7070, 16'h8080, 16'h9090, 2);
		wait_drained(200);
		vlan_drop_flags = '0;
		report_test("vlan drop");
	endtask

	task automatic back_to_back();
		logic done;
		int   max_in_flight;
		done = 1'b0;
		max_in_flight = 0;
		fork
			begin
				for (int p = 0; p < 8; p++)
					send_packet(vlan_id_t'(12'h300 + p), container_t'(p * 16'h0111),
						16'h1234, 16'hfedc, 1 + (p % 2));
				done = 1'b1;
			end
			while (!done) begin
				@(negedge clk);
				if ($countones(rmt_pipeline_i.stage_valid) > max_in_flight)
					max_in_flight = $countones(rmt_pipeline_i.stage_valid);
			end
		join
		wait_drained(200);
		assert (max_in_flight >= 2) else begin
			$display("FAILED at %0t: at most %0d header vectors in flight", $time,
				max_in_flight);
			tb_errors++;
		end
		report_test("back to back");
	endtask

	task automatic back_pressure();
		logic saw_full;
		saw_full = 1'b0;
		stall_random = 1'b1;
		for (int p = 0; p < 4; p++)
			send_packet(vlan_id_t'($random(seed)) & 12'hfe0, container_t'($random(seed)),
				container_t'($random(seed)), container_t'($random(seed)), 3);
		hold_low = 1'b1;
		fork
			for (int p = 0; p < 6; p++)
				send_packet(12'h400, container_t'($random(seed)), container_t'($random(seed)),
					container_t'($random(seed)), 4);
			begin
				for (int i = 0; i < 200 && !saw_full; i++) begin
					@(negedge clk);
					saw_full = !s_ready;
				end
				repeat (4) @(posedge clk);
				#1;
				hold_low = 1'b0;
			end
		join
		wait_drained(400);
		stall_random = 1'b0;
		assert (saw_full) else begin
			$display("FAILED at %0t: s_ready never dropped under back-pressure", $time);
			tb_errors++;
		end
		report_test("back pressure");
	endtask

	task automatic random_mix();
		vlan_drop_flags = $random(seed);
		stall_random = 1'b1;
		for (int p = 0; p < 40; p++)
			send_packet(vlan_id_t'($random(seed)), container_t'($random(seed)),
				container_t'($random(seed)), container_t'($random(seed)),
				($random(seed) & 7) + 1);
		wait_drained(800);
		stall_random = 1'b0;
		vlan_drop_flags = '0;
		report_test("random mix");
	endtask

	initial begin
		seed = 33446;
		aresetn = 1'b0;
		s_valid = 1'b0;
		s_beat = '0;
		vlan_drop_flags = '0;
		stall_random = 1'b0;
		hold_low = 1'b1;
		tb_errors = 0;
		errors_before = 0;
		repeat (4) @(posedge clk);
		#1;
		aresetn = 1'b1;
		hold_low = 1'b0;

		single_beat_packet();
		multi_beat_packets();
		vlan_drop();
		back_to_back();
		back_pressure();
		random_mix();

		total_errors = tb_errors + rx_errors;
		$display("%0d beats checked, %0d errors", rx_checks, total_errors);
		if (total_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+source
source/rmt_pkg.sv
source/header_parser.sv
source/sync_fifo.sv
source/match_action_stage.sv
source/deparser.sv
source/rmt_pipeline.sv
bench/rmt_pipeline_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= rmt_pipeline_tb
LOG ?= sim.log
FLIST ?= src.f
OBJ_DIR ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FLIST)) source/rmt_consts.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
